// ==== streaming_sink.f ====
+incdir+bench
src/sls_pkg.sv
src/lane_deskew.sv
src/sink_adaptation.sv
src/burst_framer.sv
src/sink_mgmt_regs.sv
src/streaming_sink.sv
bench/streaming_sink_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FILELIST   = streaming_sink.f
TB_TOP     = streaming_sink_tb
RTL_TOP    = streaming_sink
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
PASS_MSG   = Verification passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/sink_checks.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference framing and compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SINK_CHECKS_SVH
`define SINK_CHECKS_SVH

typedef struct packed {
   logic [64*LANES-1:0] data;
   logic [3:0]          sync;
   logic                sob;
   logic                eob;
} exp_beat_t;

exp_beat_t           exp_q [$];
logic [64*LANES-1:0] payload_q [$];

// Each data beat of a burst goes out once, first and last flagged
function automatic void frame_burst(input logic [3:0] burst_sync);
   exp_beat_t e;
   int        n;
   n = payload_q.size();
   for (int i = 0; i < n; i++) begin
      e.data = payload_q[i];
      e.sync = burst_sync;
      e.sob  = (i == 0);
      e.eob  = (i == n - 1);
      exp_q.push_back(e);
   end
endfunction

task automatic check_beat(input exp_beat_t want, input logic [64*LANES-1:0] got_data,
                          input logic [3:0] got_sync, input logic got_sob,
                          input logic got_eob);
   if (got_data !== want.data) begin
      $display("ERROR t=%0t data got=%h exp=%h", $time, got_data, want.data);
      stop_run();
   end else if (got_sync !== want.sync) begin
      $display("ERROR t=%0t sync got=%h exp=%h", $time, got_sync, want.sync);
      stop_run();
   end else if (got_sob !== want.sob) begin
      $display("ERROR t=%0t start_of_burst got=%b exp=%b", $time, got_sob, want.sob);
      stop_run();
   end else if (got_eob !== want.eob) begin
      $display("ERROR t=%0t end_of_burst got=%b exp=%b", $time, got_eob, want.eob);
      stop_run();
   end
endtask

task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] want);
   if (got !== want) begin
      $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, want);
      stop_run();
   end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
   if (got !== want) begin
      $display("ERROR t=%0t %s got=%b exp=%b", $time, name, got, want);
      stop_run();
   end
endtask

`endif

// ==== bench/streaming_sink_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streaming sink testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module streaming_sink_tb;
   import sls_pkg::*;

   localparam int LANES       = 4;
   localparam int BURSTS      = 8;
   localparam int MAX_LEN     = 6;
   localparam int PHASES      = 5;
   // Start, end and idle rows per burst, doubled by gap rows
   localparam int TOTAL_BEATS = PHASES * BURSTS * (MAX_LEN + 3) * 2;
   localparam int CYCLE_LIMIT = 2 * TOTAL_BEATS + 2000;

   typedef lane_word_t [LANES-1:0] row_t;

   logic                 clock;
   logic                 arst_n;
   row_t                 rx_lane;
   logic [64*LANES-1:0]  data;
   logic [3:0]           sync;
   logic                 valid;
   logic                 ready;
   logic                 start_of_burst;
   logic                 end_of_burst;
   logic                 link_up;
   logic                 wb_cyc;
   logic                 wb_stb;
   logic                 wb_we;
   logic [WB_ADDR_W-1:0] wb_adr;
   logic [31:0]          wb_dat_w;
   logic [3:0]           wb_sel;
   logic [31:0]          wb_dat_r;
   logic                 wb_ack;

   row_t hist [8];
   int   skew [LANES];
   int   crc_count [LANES];
   int   row_ctr;
   int   ready_mode;
   int   low_run;
   int   cycles;
   logic lossy;

   `include "sink_checks.svh"

   streaming_sink #(
      .lanes                 (LANES),
      .skew_depth            (8),
      .adaptation_fifo_depth (16)
   ) u_streaming_sink (
      .clock (clock), .arst_n (arst_n), .rx_lane (rx_lane),
      .data (data), .sync (sync), .valid (valid), .ready (ready),
      .start_of_burst (start_of_burst), .end_of_burst (end_of_burst), .link_up (link_up),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_dat_w (wb_dat_w), .wb_sel (wb_sel), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
   );

   initial clock = 1'b0;
   always #50 clock = ~clock;

   task automatic stop_run();
      $display("Verification failed");
      $fatal(1, "Run stopped at first error");
   endtask

   always @(posedge clock) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, %0d beats still expected", cycles, exp_q.size());
         stop_run();
      end
   end

   // User side handshake, sampled mid cycle
   always @(negedge clock) begin
      if (arst_n && valid && ready) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected output beat at t=%0t with nothing left to expect", $time);
            stop_run();
         end else if (lossy) begin
            // Beats lost to overflow are skipped
            while (exp_q.size() > 0 && exp_q[0].data !== data) begin
               void'(exp_q.pop_front());
            end
            if (exp_q.size() == 0) begin
               $display("Output beat at t=%0t is not a later beat of the sequence", $time);
               stop_run();
            end else begin
               void'(exp_q.pop_front());
            end
         end else begin
            check_beat(exp_q.pop_front(), data, sync, start_of_burst, end_of_burst);
         end
      end
   end

   function automatic row_t ctrl_row(input ctrl_code_t code, input logic [3:0] s);
      row_t r;
      for (int l = 0; l < LANES; l++) begin
         r[l].valid   = 1'b1;
         r[l].ctrl    = 1'b1;
         r[l].crc_err = 1'b0;
         r[l].data    = {(l == 0 || code == CODE_ALIGN) ? code : CODE_IDLE, 52'h0, s};
      end
      return r;
   endfunction

   // One clock of lane words, each lane delayed by its own skew
   task automatic drive_cycle(input row_t row);
      @(posedge clock);
      #5;
      for (int i = 7; i > 0; i--) begin
         hist[i] = hist[i-1];
      end
      hist[0] = row;
      for (int l = 0; l < LANES; l++) begin
         rx_lane[l] = hist[skew[l]][l];
      end
      if (ready_mode == 0) begin
         ready = 1'b1;
      end else if (ready_mode == 2) begin
         ready = 1'b0;
      end else begin
         ready = (low_run >= 3) || (($urandom % 4) != 0);
      end
      low_run = ready ? 0 : low_run + 1;
   endtask

   task automatic push_row(input row_t row);
      if (row_ctr % 32 == 0) begin
         drive_cycle(ctrl_row(CODE_ALIGN, 4'h0));
      end
      drive_cycle(row);
      row_ctr++;
   endtask

   task automatic send_burst(input int len, input logic gaps, input logic inject);
      row_t                r;
      row_t                rows [$];
      logic [64*LANES-1:0] flat;
      logic [LANES-1:0]    mask;
      logic [3:0]          s;
      s = 4'($urandom);
      payload_q.delete();
      for (int i = 0; i < len; i++) begin
         mask = inject ? LANES'($urandom) : '0;
         for (int l = 0; l < LANES; l++) begin
            r[l].valid   = 1'b1;
            r[l].ctrl    = 1'b0;
            r[l].crc_err = mask[l];
            r[l].data    = {$urandom, $urandom};
            flat[64*l +: 64] = r[l].data;
            crc_count[l] += int'(mask[l]);
         end
         rows.push_back(r);
         payload_q.push_back(flat);
      end
      frame_burst(s);
      push_row(ctrl_row(CODE_BURST_START, s));
      foreach (rows[i]) begin
         push_row(rows[i]);
         if (gaps) begin
            push_row('0);
         end
      end
      push_row(ctrl_row(CODE_BURST_END, 4'h0));
      push_row(ctrl_row(CODE_IDLE, 4'h0));
   endtask

   task automatic send_phase(input int count, input logic gaps, input logic inject,
                             input logic single);
      for (int b = 0; b < count; b++) begin
         send_burst((single && b == 0) ? 1 : 1 + int'($urandom % MAX_LEN), gaps, inject);
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_q.size() != 0 || valid) && n < 200) begin
         push_row('0);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected beats never came out", exp_q.size());
         stop_run();
      end
   endtask

   task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      int n;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      wb_sel   = 4'hf;
      drive_cycle('0);
      n = 1;
      while (!wb_ack && n < 8) begin
         drive_cycle('0);
         n++;
      end
      if (!wb_ack) begin
         $display("No Wishbone acknowledge for address %0d", adr);
         stop_run();
      end
      rdat   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_check(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] want,
                             input string name);
      logic [31:0] rd;
      wb_access(1'b0, adr, 32'h0, rd);
      check_reg(name, rd, want);
   endtask

   initial begin : main_seq
      logic [31:0] rd;
      logic [31:0] base [LANES];
      row_t        idle_row;
      row_t        align_row;
      int          n;
      void'($urandom(32'hda2b_e37a));
      arst_n     = 1'b0;
      rx_lane    = '0;
      ready      = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      wb_sel     = '0;
      ready_mode = 0;
      low_run    = 0;
      lossy      = 1'b0;
      row_ctr    = 0;
      cycles     = 0;
      for (int l = 0; l < LANES; l++) begin
         skew[l]      = int'($urandom % 6);
         crc_count[l] = 0;
      end
      for (int i = 0; i < 8; i++) begin
         hist[i] = '0;
      end
      repeat (2) @(posedge clock);
      #5 arst_n = 1'b1;
      check_bit("link_up", link_up, 1'b0);

      // Lock on the first markers
      n = 0;
      while (!link_up && n < 100) begin
         push_row('0);
         n++;
      end
      check_bit("link_up", link_up, 1'b1);
      read_check(WB_ADDR_W'(0), 32'h1, "status");

      // Full rate, then random user stalls on a half rate link
      send_phase(BURSTS, 1'b0, 1'b0, 1'b1);
      wait_drain();
      ready_mode = 1;
      send_phase(BURSTS, 1'b1, 1'b0, 1'b0);
      ready_mode = 0;
      wait_drain();

      // Long stall overflows the FIFO
      lossy      = 1'b1;
      ready_mode = 2;
      send_phase(BURSTS, 1'b0, 1'b0, 1'b0);
      ready_mode = 0;
      send_phase(3, 1'b0, 1'b0, 1'b0);
      wait_drain();
      lossy = 1'b0;
      wb_access(1'b0, WB_ADDR_W'(9), 32'h0, rd);
      if (rd[15:0] == 16'h0) begin
         $display("ERROR t=%0t overflow_count got=%h exp=at least 1", $time, rd);
         stop_run();
      end

      // CRC error counting and clear
      for (int l = 0; l < LANES; l++) begin
         wb_access(1'b0, WB_ADDR_W'(l + 1), 32'h0, base[l]);
         crc_count[l] = 0;
      end
      send_phase(BURSTS, 1'b0, 1'b1, 1'b0);
      wait_drain();
      for (int l = 0; l < LANES; l++) begin
         read_check(WB_ADDR_W'(l + 1), base[l] + 32'(crc_count[l]),
                    $sformatf("crc_count[%0d]", l));
      end
      wb_access(1'b1, WB_ADDR_W'(10), 32'h1, rd);
      for (int l = 0; l < LANES; l++) begin
         read_check(WB_ADDR_W'(l + 1), 32'h0, $sformatf("crc_count[%0d]", l));
      end
      read_check(WB_ADDR_W'(9), 32'h0, "overflow_count");

      // Marker on two lanes only breaks the lock
      while (row_ctr % 32 != 1) begin
         push_row('0);
      end
      idle_row  = ctrl_row(CODE_IDLE, 4'h0);
      align_row = ctrl_row(CODE_ALIGN, 4'h0);
      push_row({idle_row[LANES-1:2], align_row[1:0]});
      n = 0;
      while (link_up && n < 40) begin
         push_row('0);
         n++;
      end
      check_bit("link_up", link_up, 1'b0);
      n = 0;
      while (!link_up && n < 100) begin
         push_row('0);
         n++;
      end
      check_bit("link_up", link_up, 1'b1);
      send_phase(4, 1'b0, 1'b0, 1'b0);
      wait_drain();

      $display("Verification passed");
      $finish;
   end

endmodule

// ==== src/streaming_sink.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streaming sink top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module streaming_sink #(
   parameter int lanes                 = 4,
   parameter int skew_depth            = 8,
   parameter int adaptation_fifo_depth = 16
) (
   input  logic                             clock,
   input  logic                             arst_n,
   input  sls_pkg::lane_word_t [lanes-1:0]  rx_lane,

   // User port
   output logic [64*lanes-1:0]              data,
   output logic [3:0]                       sync,
   output logic                             valid,
   input  logic                             ready,
   output logic                             start_of_burst,
   output logic                             end_of_burst,
   output logic                             link_up,

   // Wishbone slave
   input  logic                             wb_cyc,
   input  logic                             wb_stb,
   input  logic                             wb_we,
   input  logic [sls_pkg::WB_ADDR_W-1:0]    wb_adr,
   input  logic [31:0]                      wb_dat_w,
   input  logic [3:0]                       wb_sel,
   output logic [31:0]                      wb_dat_r,
   output logic                             wb_ack
);
   import sls_pkg::*;

   beat_t      aligned_beat;
   logic       aligned_valid;
   beat_t      fifo_beat;
   logic       fifo_valid;
   logic       fifo_ready;
   err_pulse_t err;

   lane_deskew #(
      .lanes      (lanes),
      .skew_depth (skew_depth)
   ) u_lane_deskew (
      .clock      (clock),
      .arst_n     (arst_n),
      .rx_lane    (rx_lane),
      .beat       (aligned_beat),
      .beat_valid (aligned_valid),
      .aligned    (link_up)
   );

   sink_adaptation #(
      .lanes                 (lanes),
      .adaptation_fifo_depth (adaptation_fifo_depth)
   ) u_sink_adaptation (
      .clock     (clock),
      .arst_n    (arst_n),
      .in_beat   (aligned_beat),
      .in_valid  (aligned_valid),
      .out_beat  (fifo_beat),
      .out_valid (fifo_valid),
      .out_ready (fifo_ready),
      .err       (err)
   );

   burst_framer #(
      .lanes (lanes)
   ) u_burst_framer (
      .clock          (clock),
      .arst_n         (arst_n),
      .in_beat        (fifo_beat),
      .in_valid       (fifo_valid),
      .in_ready       (fifo_ready),
      .data           (data),
      .sync           (sync),
      .valid          (valid),
      .start_of_burst (start_of_burst),
      .end_of_burst   (end_of_burst),
      .ready          (ready)
   );

   sink_mgmt_regs #(
      .lanes (lanes)
   ) u_sink_mgmt_regs (
      .clock    (clock),
      .arst_n   (arst_n),
      .err      (err),
      .link_up  (link_up),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_sel   (wb_sel),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

endmodule

// ==== src/sink_mgmt_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone status and error counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sink_mgmt_regs #(
   parameter int lanes = 4
) (
   input  logic                          clock,
   input  logic                          arst_n,
   input  sls_pkg::err_pulse_t           err,
   input  logic                          link_up,
   input  logic                          wb_cyc,
   input  logic                          wb_stb,
   input  logic                          wb_we,
   input  logic [sls_pkg::WB_ADDR_W-1:0] wb_adr,
   input  logic [31:0]                   wb_dat_w,
   input  logic [3:0]                    wb_sel,
   output logic [31:0]                   wb_dat_r,
   output logic                          wb_ack
);
   import sls_pkg::*;

   localparam logic [WB_ADDR_W-1:0] ADDR_STATUS   = WB_ADDR_W'(0);
   localparam logic [WB_ADDR_W-1:0] ADDR_OVERFLOW = WB_ADDR_W'(9);
   localparam logic [WB_ADDR_W-1:0] ADDR_CLEAR    = WB_ADDR_W'(10);

   logic [15:0] crc_cnt [lanes];
   logic [15:0] ovf_cnt;
   logic        wb_req;
   logic        clear;
   logic [31:0] rd_data;

   // New cycle only when not already acknowledging
   assign wb_req = wb_cyc && wb_stb && !wb_ack;
   assign clear  = wb_req && wb_we && (wb_adr == ADDR_CLEAR) && wb_sel[0] && wb_dat_w[0];

   always_comb begin
      rd_data = '0;
      if (wb_adr == ADDR_STATUS) begin
         rd_data[0] = link_up;
      end else if (wb_adr == ADDR_OVERFLOW) begin
         rd_data[15:0] = ovf_cnt;
      end
      for (int l = 0; l < lanes; l++) begin
         if (wb_adr == WB_ADDR_W'(l + 1)) begin
            rd_data[15:0] = crc_cnt[l];
         end
      end
   end

   // Saturating counters
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack  <= 1'b0;
         ovf_cnt <= '0;
         for (int l = 0; l < lanes; l++) begin
            crc_cnt[l] <= '0;
         end
      end else begin
         wb_ack <= wb_req;
         if (clear) begin
            ovf_cnt <= '0;
         end else if (err.overflow && ovf_cnt != 16'hffff) begin
            ovf_cnt <= ovf_cnt + 1'b1;
         end
         for (int l = 0; l < lanes; l++) begin
            if (clear) begin
               crc_cnt[l] <= '0;
            end else if (err.crc[l] && crc_cnt[l] != 16'hffff) begin
               crc_cnt[l] <= crc_cnt[l] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      if (wb_req) begin
         wb_dat_r <= rd_data;
      end
   end

endmodule

// ==== src/burst_framer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst framing and sync
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module burst_framer #(
   parameter int lanes = 4
) (
   input  logic                  clock,
   input  logic                  arst_n,
   input  sls_pkg::beat_t        in_beat,
   input  logic                  in_valid,
   output logic                  in_ready,
   output logic [64*lanes-1:0]   data,
   output logic [3:0]            sync,
   output logic                  valid,
   output logic                  start_of_burst,
   output logic                  end_of_burst,
   input  logic                  ready
);
   import sls_pkg::*;

   ctrl_code_t          code;
   logic                take;
   logic                in_burst;
   logic                sob_armed;
   logic                hold_valid;
   logic                hold_sob;
   logic [64*lanes-1:0] hold_data;
   logic [3:0]          sync_q;
   logic                emit;
   logic                emit_last;

   // Lane 0 carries the control code
   assign code     = ctrl_code_t'(in_beat.data[0][63:56]);
   assign in_ready = !valid || ready;
   assign take     = in_valid && in_ready;

   always_comb begin
      emit      = 1'b0;
      emit_last = 1'b0;
      if (take && hold_valid) begin
         if (!in_beat.ctrl) begin
            emit = 1'b1;
         end else if (code == CODE_BURST_END || code == CODE_BURST_START) begin
            // Held beat closes the burst
            emit      = 1'b1;
            emit_last = 1'b1;
         end
      end
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         valid          <= 1'b0;
         start_of_burst <= 1'b0;
         end_of_burst   <= 1'b0;
         sync           <= '0;
         sync_q         <= '0;
         in_burst       <= 1'b0;
         sob_armed      <= 1'b0;
         hold_valid     <= 1'b0;
         hold_sob       <= 1'b0;
      end else begin
         if (emit) begin
            valid          <= 1'b1;
            start_of_burst <= hold_sob;
            end_of_burst   <= emit_last;
            sync           <= sync_q;
         end else if (ready) begin
            valid          <= 1'b0;
            start_of_burst <= 1'b0;
            end_of_burst   <= 1'b0;
         end

         if (take && in_beat.ctrl) begin
            if (code == CODE_BURST_START) begin
               in_burst   <= 1'b1;
               sob_armed  <= 1'b1;
               sync_q     <= in_beat.data[0][3:0];
               hold_valid <= 1'b0;
            end else if (code == CODE_BURST_END) begin
               in_burst   <= 1'b0;
               sob_armed  <= 1'b0;
               hold_valid <= 1'b0;
            end
         end else if (take && in_burst) begin
            hold_valid <= 1'b1;
            hold_sob   <= sob_armed;
            sob_armed  <= 1'b0;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (take && !in_beat.ctrl && in_burst) begin
         hold_data <= in_beat.data[lanes-1:0];
      end
      if (emit) begin
         data <= hold_data;
      end
   end

   a_sob_with_valid: assert property (
      @(posedge clock) disable iff (!arst_n) start_of_burst |-> valid
   );

   // User port holds its beat until taken
   a_hold_under_stall: assert property (
      @(posedge clock) disable iff (!arst_n)
      (valid && !ready) |=> (valid && $stable(data) && $stable(end_of_burst))
   );

endmodule

// ==== src/sink_adaptation.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Adaptation FIFO and error pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sink_adaptation #(
   parameter int lanes                 = 4,
   parameter int adaptation_fifo_depth = 16
) (
   input  logic                clock,
   input  logic                arst_n,
   input  sls_pkg::beat_t      in_beat,
   input  logic                in_valid,
   output sls_pkg::beat_t      out_beat,
   output logic                out_valid,
   input  logic                out_ready,
   output sls_pkg::err_pulse_t err
);
   import sls_pkg::*;

   localparam int PTR_W = (adaptation_fifo_depth > 1) ? $clog2(adaptation_fifo_depth) : 1;
   localparam int CNT_W = $clog2(adaptation_fifo_depth + 1);
   localparam logic [MAX_LANES-1:0] LANE_MASK = MAX_LANES'((1 << lanes) - 1);

   beat_t            fifo_mem [adaptation_fifo_depth];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fill;
   logic             full;
   logic             wr_en;
   logic             rd_en;
   logic             drop;

   function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
      return (p == PTR_W'(adaptation_fifo_depth - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full      = (fill == CNT_W'(adaptation_fifo_depth));
   assign out_valid = (fill != '0);
   assign out_beat  = fifo_mem[rd_ptr];
   assign rd_en     = out_valid && out_ready;
   // The link cannot be stalled so a full FIFO loses the beat
   assign wr_en     = in_valid && !full;
   assign drop      = in_valid && full;

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
         err    <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         fill <= fill + CNT_W'(wr_en) - CNT_W'(rd_en);

         // CRC flags count whether the beat was kept or not
         err.crc      <= in_valid ? (in_beat.crc_err & LANE_MASK) : '0;
         err.overflow <= drop;
      end
   end

   always_ff @(posedge clock) begin
      if (wr_en) begin
         fifo_mem[wr_ptr] <= in_beat;
      end
   end

   // Occupancy never passes the FIFO depth
   a_no_write_when_full: assert property (
      @(posedge clock) disable iff (!arst_n)
      fill <= CNT_W'(adaptation_fifo_depth)
   );

endmodule

// ==== src/lane_deskew.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane deskew with marker alignment
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lane_deskew #(
   parameter int lanes      = 4,
   parameter int skew_depth = 8
) (
   input  logic                             clock,
   input  logic                             arst_n,
   input  sls_pkg::lane_word_t [lanes-1:0]  rx_lane,
   output sls_pkg::beat_t                   beat,
   output logic                             beat_valid,
   output logic                             aligned
);
   import sls_pkg::*;

   localparam int PTR_W = (skew_depth > 1) ? $clog2(skew_depth) : 1;
   localparam int CNT_W = $clog2(skew_depth + 1);

   lane_word_t       buf_mem [lanes][skew_depth];
   logic [PTR_W-1:0] wr_ptr  [lanes];
   logic [PTR_W-1:0] rd_ptr  [lanes];
   logic [CNT_W-1:0] fill    [lanes];
   lane_word_t       head    [lanes];
   logic [lanes-1:0] seen;
   logic [lanes-1:0] push;
   logic [lanes-1:0] full;
   logic [lanes-1:0] nonempty;
   logic [lanes-1:0] head_align;
   logic             pop;
   logic             all_align;
   logic             some_align;
   logic             overflow;
   logic             resync;
   beat_t            next_beat;

   function automatic logic is_align(lane_word_t w);
      return w.valid && w.ctrl && (w.data[63:56] == CODE_ALIGN);
   endfunction

   function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
      return (p == PTR_W'(skew_depth - 1)) ? '0 : p + 1'b1;
   endfunction

   always_comb begin
      next_beat = '0;
      for (int l = 0; l < lanes; l++) begin
         head[l]                = buf_mem[l][rd_ptr[l]];
         nonempty[l]            = (fill[l] != '0);
         full[l]                = (fill[l] == CNT_W'(skew_depth));
         head_align[l]          = nonempty[l] && is_align(head[l]);
         // Hunt for the first marker, then keep every word
         push[l]                = rx_lane[l].valid && (seen[l] || is_align(rx_lane[l]));
         next_beat.crc_err[l]   = head[l].crc_err;
         next_beat.data[l]      = head[l].data;
      end
      next_beat.ctrl = head[0].ctrl;
      all_align      = &head_align;
      some_align     = (|head_align) && !all_align;
      // Searching pops only the marker row; aligned pops any full row
      pop            = aligned ? &nonempty : all_align;
      overflow       = |(push & full) && !pop;
      resync         = overflow || (aligned && pop && some_align);
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         aligned    <= 1'b0;
         beat_valid <= 1'b0;
         seen       <= '0;
         for (int l = 0; l < lanes; l++) begin
            wr_ptr[l] <= '0;
            rd_ptr[l] <= '0;
            fill[l]   <= '0;
         end
      end else begin
         // Marker rows are consumed here
         beat_valid <= aligned && pop && !all_align && !resync;
         if (resync) begin
            aligned <= 1'b0;
            seen    <= '0;
            for (int l = 0; l < lanes; l++) begin
               wr_ptr[l] <= '0;
               rd_ptr[l] <= '0;
               fill[l]   <= '0;
            end
         end else begin
            if (pop) begin
               aligned <= 1'b1;
            end
            seen <= seen | push;
            for (int l = 0; l < lanes; l++) begin
               if (push[l]) begin
                  wr_ptr[l] <= ptr_inc(wr_ptr[l]);
               end
               if (pop) begin
                  rd_ptr[l] <= ptr_inc(rd_ptr[l]);
               end
               fill[l] <= fill[l] + CNT_W'(push[l]) - CNT_W'(pop);
            end
         end
      end
   end

   // Skew buffer storage and beat payload
   always_ff @(posedge clock) begin
      for (int l = 0; l < lanes; l++) begin
         if (push[l] && !resync) begin
            buf_mem[l][wr_ptr[l]] <= rx_lane[l];
         end
      end
      if (pop) begin
         beat <= next_beat;
      end
   end

   a_beat_only_when_aligned: assert property (
      @(posedge clock) disable iff (!arst_n) beat_valid |-> aligned
   );

endmodule

// ==== src/sls_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streaming sink shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sls_pkg;

   // Upper bound on the lane count of any instance
   localparam int MAX_LANES = 8;

   // Wishbone register address width
   localparam int WB_ADDR_W = 4;

   // Control codes live in bits 63:56 of a control word
   typedef enum logic [7:0] {
      CODE_ALIGN       = 8'h78,
      CODE_BURST_START = 8'h1e,
      CODE_BURST_END   = 8'he1,
      CODE_IDLE        = 8'h07
   } ctrl_code_t;

   // One decoded word from a single lane
   typedef struct packed {
      logic        valid;
      logic        ctrl;
      logic        crc_err;
      logic [63:0] data;
   } lane_word_t;

   // One aligned beat across all lanes, low lanes in use
   typedef struct packed {
      logic                        ctrl;
      logic [MAX_LANES-1:0]        crc_err;
      logic [MAX_LANES-1:0][63:0]  data;
   } beat_t;

   // Error pulses toward the register block
   typedef struct packed {
      logic                 overflow;
      logic [MAX_LANES-1:0] crc;
   } err_pulse_t;

endpackage
